// File: include/des_config.svh
`ifndef DES_CONFIG_SVH
`define DES_CONFIG_SVH

// Feistel rounds per block
`define DES_ROUNDS 16

`define DES_BLOCK_W 64   // Data block
`define DES_HALF_W 32    // One Feistel half
`define DES_KEY_W 64     // Key incl. parity bits
`define DES_SUBKEY_W 48  // Round key after PC-2
`define DES_KIDX_W 4     // Round / subkey index

`endif

// File: hw/des_pkg.sv
`default_nettype none

`include "des_config.svh"

package des_pkg;

	// Bit 1 is the MSB, numbering as in FIPS 46
	typedef logic [1:`DES_BLOCK_W] block_t;
	typedef logic [1:`DES_HALF_W] half_t;
	typedef logic [1:`DES_SUBKEY_W] subkey_t;
	typedef logic [`DES_KIDX_W-1:0] kidx_t;

	// Carried as a single bit on the ports
	typedef enum logic {
		op_encrypt = 1'b0,
		op_decrypt = 1'b1
	} des_op_e;

	typedef enum logic [1:0] {
		st_idle,
		st_fetch,  // Request waiting for grant
		st_round,  // Subkey on the bus, round applied
		st_finish
	} engine_state_e;

	typedef enum logic [1:0] {
		sk_idle,
		sk_expand,  // One subkey written per cycle
		sk_ready
	} sched_state_e;

	// Entry index is {b1, b6, b2..b5}, i.e. row*16 + col
	typedef logic [0:63][3:0] sbox_t;

	localparam sbox_t sbox_table [0:7] = '{
		256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D, // S1
		256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9, // S2
		256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C, // S3
		256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E, // S4
		256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453, // S5
		256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D, // S6
		256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C, // S7
		256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B  // S8
	};

endpackage

`default_nettype wire

// File: hw/des_key_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Subkey read channel between one engine and the arbiter
interface des_key_bus_if;
	logic req;                 // Held with idx until gnt
	logic gnt;
	des_pkg::kidx_t idx;
	des_pkg::subkey_t subkey;  // Valid the cycle after gnt

	modport requester (
		output req,
		output idx,
		input  gnt,
		input  subkey
	);

	modport server (
		input  req,
		input  idx,
		output gnt,
		output subkey
	);
endinterface

`default_nettype wire

// File: hw/des_key_schedule.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_key_schedule (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                key_load,
	input  wire logic [1:`DES_KEY_W] key,
	input  wire logic                key_lock,   // An engine is mid-job
	output logic                     wr_en,
	output des_pkg::kidx_t           wr_idx,
	output des_pkg::subkey_t         wr_subkey,
	output logic                     key_ready
);

	localparam int CD_W = 56;  // Key without parity bits
	localparam int PC1 [CD_W] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};
	localparam int PC2 [`DES_SUBKEY_W] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};
	// Rounds 1, 2, 9 and 16 rotate by one, the rest by two
	localparam logic [0:`DES_ROUNDS-1] TWO_SHIFT = 16'b0011_1111_0111_1110;

	des_pkg::sched_state_e state;
	des_pkg::kidx_t        cnt;
	logic [1:CD_W/2]       c_q, d_q;
	logic [1:CD_W/2]       c_rot, d_rot;
	logic [1:CD_W]         key_pc1;
	logic [1:CD_W]         cd_rot;
	logic                  load_ok;

	// No reload while expanding or while an engine uses the store
	assign load_ok = key_load && !key_lock && (state != des_pkg::sk_expand);

	always_comb begin
		for (int i = 0; i < CD_W; i++) begin
			key_pc1[i+1] = key[PC1[i]];
		end
	end

	always_comb begin
		if (TWO_SHIFT[cnt]) begin
			c_rot = {c_q[3:CD_W/2], c_q[1:2]};
			d_rot = {d_q[3:CD_W/2], d_q[1:2]};
		end else begin
			c_rot = {c_q[2:CD_W/2], c_q[1]};
			d_rot = {d_q[2:CD_W/2], d_q[1]};
		end
		cd_rot = {c_rot, d_rot};
		for (int i = 0; i < `DES_SUBKEY_W; i++) begin
			wr_subkey[i+1] = cd_rot[PC2[i]];  // PC-2 on rotated halves
		end
	end

	assign wr_en     = (state == des_pkg::sk_expand);
	assign wr_idx    = cnt;
	assign key_ready = (state == des_pkg::sk_ready);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= des_pkg::sk_idle;
			cnt   <= '0;
		end else begin
			case (state)
				des_pkg::sk_expand: begin
					cnt <= cnt + 1'b1;
					if (cnt == des_pkg::kidx_t'(`DES_ROUNDS - 1)) begin
						state <= des_pkg::sk_ready;  // Last subkey written this cycle
					end
				end
				des_pkg::sk_idle, des_pkg::sk_ready: begin
					if (load_ok) begin
						state <= des_pkg::sk_expand;
						cnt   <= '0;
					end
				end
				default: state <= des_pkg::sk_idle;
			endcase
		end
	end

	// C and D halves, rotated once per written subkey
	always_ff @(posedge clk) begin
		if (load_ok) begin
			c_q <= key_pc1[1:CD_W/2];
			d_q <= key_pc1[CD_W/2+1:CD_W];
		end else if (wr_en) begin
			c_q <= c_rot;
			d_q <= d_rot;
		end
	end

endmodule

`default_nettype wire

// File: hw/des_key_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_key_arbiter (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             key_ready,
	input  wire logic             wr_en,
	input  wire des_pkg::kidx_t   wr_idx,
	input  wire des_pkg::subkey_t wr_subkey,
	des_key_bus_if.server         a_bus,
	des_key_bus_if.server         b_bus
);

	des_pkg::subkey_t mem [`DES_ROUNDS];  // One entry per round
	des_pkg::subkey_t rd_data;
	logic             prio_b;             // B wins a tie when set
	logic             gnt_a, gnt_b;

	// Store is only read once the schedule has finished
	always_comb begin
		gnt_a = key_ready && a_bus.req && (!b_bus.req || !prio_b);
		gnt_b = key_ready && b_bus.req && (!a_bus.req || prio_b);
	end

	assign a_bus.gnt = gnt_a;
	assign b_bus.gnt = gnt_b;

	// Priority passes to the other engine after a grant
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_b <= 1'b0;
		end else if (gnt_a) begin
			prio_b <= 1'b1;
		end else if (gnt_b) begin
			prio_b <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_idx] <= wr_subkey;
		end
	end

	// Registered read port, data lands the cycle after gnt
	always_ff @(posedge clk) begin
		if (gnt_a || gnt_b) begin
			rd_data <= mem[gnt_b ? b_bus.idx : a_bus.idx];
		end
	end

	// Only the engine granted last cycle samples it
	assign a_bus.subkey = rd_data;
	assign b_bus.subkey = rd_data;

endmodule

`default_nettype wire

// File: hw/des_round.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_round (
	input  wire des_pkg::half_t   l_in,
	input  wire des_pkg::half_t   r_in,
	input  wire des_pkg::subkey_t subkey,
	output des_pkg::half_t        l_out,
	output des_pkg::half_t        r_out
);

	localparam int NUM_SBOX = `DES_SUBKEY_W / 6;
	localparam int P_TAB [`DES_HALF_W] = '{
		16,  7, 20, 21, 29, 12, 28, 17,
		 1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9,
		19, 13, 30,  6, 22, 11,  4, 25
	};

	des_pkg::subkey_t r_exp;   // E(R)
	des_pkg::subkey_t mixed;   // E(R) xor K
	des_pkg::half_t   s_out;
	des_pkg::half_t   f_out;   // After P

	// E table: group g takes bits 4g .. 4g+5 of R, wrapping at both ends
	always_comb begin
		for (int j = 0; j < `DES_SUBKEY_W; j++) begin
			r_exp[j+1] = r_in[((4 * (j / 6) + (j % 6) + `DES_HALF_W - 1) % `DES_HALF_W) + 1];
		end
	end

	assign mixed = r_exp ^ subkey;

	always_comb begin
		logic [5:0] six;
		for (int i = 0; i < NUM_SBOX; i++) begin
			// Outer bits pick the row, inner four the column
			six = {mixed[6*i+1], mixed[6*i+6], mixed[6*i+2 +: 4]};
			s_out[4*i+1 +: 4] = des_pkg::sbox_table[i][six];
		end
	end

	always_comb begin
		for (int i = 0; i < `DES_HALF_W; i++) begin
			f_out[i+1] = s_out[P_TAB[i]];
		end
	end

	assign l_out = r_in;          // Halves swap every round
	assign r_out = l_in ^ f_out;

endmodule

`default_nettype wire

// File: hw/des_crypt_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_crypt_engine (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            start,
	input  wire logic            op,         // des_op_e as one bit
	input  wire des_pkg::block_t block_in,
	input  wire logic            key_ready,
	des_key_bus_if.requester     key_bus,
	output logic                 done,
	output logic                 busy,
	output des_pkg::block_t      result      // Held until next accepted start
);

	localparam int IP [`DES_BLOCK_W] = '{
		58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
		57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
	};
	localparam int IP_INV [`DES_BLOCK_W] = '{
		40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
		38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
		36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
		34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
	};
	localparam des_pkg::kidx_t LAST_ROUND = des_pkg::kidx_t'(`DES_ROUNDS - 1);

	des_pkg::engine_state_e state;
	des_pkg::des_op_e       op_q;
	des_pkg::kidx_t         round_q;
	des_pkg::half_t         l_q, r_q;
	des_pkg::half_t         l_nxt, r_nxt;
	des_pkg::block_t        block_ip;
	des_pkg::block_t        preout;      // R16 L16
	des_pkg::block_t        preout_inv;
	logic                   accept;

	assign accept = start && key_ready && (state == des_pkg::st_idle);
	assign busy   = (state != des_pkg::st_idle);

	// Decryption walks the subkeys backwards
	assign key_bus.req = (state == des_pkg::st_fetch);
	assign key_bus.idx = (op_q == des_pkg::op_decrypt) ? LAST_ROUND - round_q : round_q;

	always_comb begin
		for (int i = 0; i < `DES_BLOCK_W; i++) begin
			block_ip[i+1] = block_in[IP[i]];
		end
	end

	assign preout = {r_q, l_q};  // Undo the swap of the last round

	always_comb begin
		for (int i = 0; i < `DES_BLOCK_W; i++) begin
			preout_inv[i+1] = preout[IP_INV[i]];
		end
	end

	des_round u_round (
		.l_in   (l_q),
		.r_in   (r_q),
		.subkey (key_bus.subkey),  // Valid in st_round
		.l_out  (l_nxt),
		.r_out  (r_nxt)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= des_pkg::st_idle;
			round_q <= '0;
			op_q    <= des_pkg::op_encrypt;
			done    <= 1'b0;
			result  <= '0;
		end else begin
			done <= 1'b0;  // Single-cycle pulse
			case (state)
				des_pkg::st_idle: begin
					if (accept) begin
						state   <= des_pkg::st_fetch;
						round_q <= '0;
						op_q    <= des_pkg::des_op_e'(op);
					end
				end
				des_pkg::st_fetch: begin
					if (key_bus.gnt) begin
						state <= des_pkg::st_round;
					end
				end
				des_pkg::st_round: begin
					round_q <= round_q + 1'b1;
					state   <= (round_q == LAST_ROUND) ? des_pkg::st_finish : des_pkg::st_fetch;
				end
				des_pkg::st_finish: begin
					result <= preout_inv;
					done   <= 1'b1;
					state  <= des_pkg::st_idle;
				end
				default: state <= des_pkg::st_idle;
			endcase
		end
	end

	// Feistel halves
	always_ff @(posedge clk) begin
		if (accept) begin
			{l_q, r_q} <= block_ip;
		end else if (state == des_pkg::st_round) begin
			l_q <= l_nxt;
			r_q <= r_nxt;
		end
	end

endmodule

`default_nettype wire

// File: hw/des_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_subsystem (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                key_load,
	input  wire logic [1:`DES_KEY_W] key,
	output logic                     key_ready,
	input  wire logic                a_start,
	input  wire logic                a_op,
	input  wire des_pkg::block_t     a_block,
	output logic                     a_done,
	output des_pkg::block_t          a_result,
	input  wire logic                b_start,
	input  wire logic                b_op,
	input  wire des_pkg::block_t     b_block,
	output logic                     b_done,
	output des_pkg::block_t          b_result
);

	des_key_bus_if a_bus ();
	des_key_bus_if b_bus ();

	logic             wr_en;
	des_pkg::kidx_t   wr_idx;
	des_pkg::subkey_t wr_subkey;
	logic             a_busy, b_busy;
	logic             key_lock;

	assign key_lock = a_busy | b_busy;  // Keep the store stable under a running job

	des_key_schedule u_key_schedule (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_load  (key_load),
		.key       (key),
		.key_lock  (key_lock),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_subkey (wr_subkey),
		.key_ready (key_ready)
	);

	des_key_arbiter u_key_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_ready (key_ready),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_subkey (wr_subkey),
		.a_bus     (a_bus.server),
		.b_bus     (b_bus.server)
	);

	des_crypt_engine u_engine_a (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (a_start),
		.op        (a_op),
		.block_in  (a_block),
		.key_ready (key_ready),
		.key_bus   (a_bus.requester),
		.done      (a_done),
		.busy      (a_busy),
		.result    (a_result)
	);

	des_crypt_engine u_engine_b (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (b_start),
		.op        (b_op),
		.block_in  (b_block),
		.key_ready (key_ready),
		.key_bus   (b_bus.requester),
		.done      (b_done),
		.busy      (b_busy),
		.result    (b_result)
	);

endmodule

`default_nettype wire

// File: test/des_properties.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the subkey store and the engine outputs
module des_properties (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic key_ready,
	input wire logic a_gnt,
	input wire logic b_gnt,
	input wire logic a_done,
	input wire logic b_done
);

	int failures = 0;  // Failed assertions so far

	// Single read port, so at most one grant per cycle
	grant_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(a_gnt && b_gnt))
		else begin
			failures++;
			$error("Subkey read port granted to both engines in one cycle");
		end

	// Store holds stale or partial subkeys until key_ready
	no_grant_before_ready: assert property (@(posedge clk) disable iff (!rst_n)
		!key_ready |-> !(a_gnt || b_gnt))
		else begin
			failures++;
			$error("Subkey grant issued while key_ready is low");
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		a_done |=> !a_done)
		else begin
			failures++;
			$error("Channel A done held longer than one cycle");
		end

	b_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		b_done |=> !b_done)
		else begin
			failures++;
			$error("Channel B done held longer than one cycle");
		end

	// No key loaded yet when reset lifts
	ready_low_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !key_ready)
		else begin
			failures++;
			$error("key_ready high right after reset release");
		end

endmodule

`default_nettype wire

// File: test/des_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "des_config.svh"

module des_tb;

	localparam int KEY_TIMEOUT = 40;   // Schedule needs 17 cycles
	localparam int JOB_TIMEOUT = 200;  // Two engines sharing one port
	localparam int IDLE_WINDOW = 100;  // Watch time for a stray done

	// Known-answer vectors
	localparam logic [1:`DES_KEY_W] KEY1 = 64'h133457799BBCDFF1;
	localparam logic [1:`DES_KEY_W] KEY2 = 64'h0E329232EA6D0D73;
	localparam des_pkg::block_t PT1 = 64'h0123456789ABCDEF;
	localparam des_pkg::block_t CT1 = 64'h85E813540F0AB405;
	localparam des_pkg::block_t PT2 = 64'h8787878787878787;
	localparam des_pkg::block_t CT2 = 64'h0000000000000000;

	logic                clk;
	logic                rst_n;
	logic                key_load;
	logic [1:`DES_KEY_W] key;
	logic                key_ready;
	logic                a_start, a_op, a_done;
	des_pkg::block_t     a_block, a_result;
	logic                b_start, b_op, b_done;
	des_pkg::block_t     b_block, b_result;

	int     errors;
	int     timeouts;
	integer seed;      // Random block source for the concurrency test

	des_subsystem i_des_subsystem (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_load  (key_load),
		.key       (key),
		.key_ready (key_ready),
		.a_start   (a_start),
		.a_op      (a_op),
		.a_block   (a_block),
		.a_done    (a_done),
		.a_result  (a_result),
		.b_start   (b_start),
		.b_op      (b_op),
		.b_block   (b_block),
		.b_done    (b_done),
		.b_result  (b_result)
	);

	// Grants taken straight off the internal buses
	bind des_subsystem des_properties u_properties (
		.clk       (clk),
		.rst_n     (rst_n),
		.key_ready (key_ready),
		.a_gnt     (a_bus.gnt),
		.b_gnt     (b_bus.gnt),
		.a_done    (a_done),
		.b_done    (b_done)
	);

	always #50 clk = ~clk;  // 100 ns period

	task automatic check_block(input string what, input des_pkg::block_t got,
		input des_pkg::block_t exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		timeouts++;
		$display("Timeout: no %s within the allowed number of cycles", what);
	endtask

	task automatic load_key(input logic [1:`DES_KEY_W] k);
		int cycles;
		@(posedge clk);
		key_load <= 1'b1;
		key      <= k;
		@(posedge clk);
		key_load <= 1'b0;
		cycles = 0;
		@(negedge clk);  // key_ready already low here
		while (!key_ready && cycles < KEY_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (key_ready) else note_timeout("key_ready after key_load");
	endtask

	// One-cycle start strobes, both channels in the same cycle if asked
	task automatic pulse_starts(
		input logic              go_a,
		input des_pkg::des_op_e  op_a,
		input des_pkg::block_t   blk_a,
		input logic              go_b,
		input des_pkg::des_op_e  op_b,
		input des_pkg::block_t   blk_b
	);
		@(posedge clk);
		a_start <= go_a;
		a_op    <= op_a;
		a_block <= blk_a;
		b_start <= go_b;
		b_op    <= op_b;
		b_block <= blk_b;
		@(posedge clk);
		a_start <= 1'b0;
		b_start <= 1'b0;
	endtask

	task automatic wait_jobs(
		input  logic            want_a,
		input  logic            want_b,
		input  int              limit,
		output logic            seen_a,
		output logic            seen_b,
		output des_pkg::block_t res_a,
		output des_pkg::block_t res_b
	);
		int cycles;
		seen_a = 1'b0;
		seen_b = 1'b0;
		res_a  = '0;
		res_b  = '0;
		cycles = 0;
		while (((want_a && !seen_a) || (want_b && !seen_b)) && cycles < limit) begin
			@(negedge clk);  // Outputs settled
			cycles++;
			if (a_done) begin
				seen_a = 1'b1;
				res_a  = a_result;
			end
			if (b_done) begin
				seen_b = 1'b1;
				res_b  = b_result;
			end
		end
	endtask

	task automatic test_start_without_key();
		logic            seen_a, seen_b;
		des_pkg::block_t res_a, res_b;
		@(negedge clk);
		check_flag("key_ready after reset", key_ready, 1'b0);
		check_block("a_result after reset", a_result, '0);
		check_block("b_result after reset", b_result, '0);
		pulse_starts(1'b1, des_pkg::op_encrypt, PT1, 1'b0, des_pkg::op_encrypt, '0);
		wait_jobs(1'b1, 1'b0, IDLE_WINDOW, seen_a, seen_b, res_a, res_b);
		assert (!seen_a) else begin
			errors++;
			$display("Channel A finished a job that was started before any key was loaded");
		end
	endtask

	task automatic test_key_expansion();
		load_key(KEY1);
	endtask

	task automatic test_known_encrypt();
		logic            seen_a, seen_b;
		des_pkg::block_t res_a, res_b;
		pulse_starts(1'b1, des_pkg::op_encrypt, PT1, 1'b0, des_pkg::op_encrypt, '0);
		wait_jobs(1'b1, 1'b0, JOB_TIMEOUT, seen_a, seen_b, res_a, res_b);
		assert (seen_a) else note_timeout("a_done for the known-answer encryption");
		check_block("A encryption of 0123456789ABCDEF", res_a, CT1);
	endtask

	task automatic test_known_decrypt();
		logic            seen_a, seen_b;
		des_pkg::block_t res_a, res_b;
		pulse_starts(1'b0, des_pkg::op_encrypt, '0, 1'b1, des_pkg::op_decrypt, CT1);
		wait_jobs(1'b0, 1'b1, JOB_TIMEOUT, seen_a, seen_b, res_a, res_b);
		assert (seen_b) else note_timeout("b_done for the known-answer decryption");
		check_block("B decryption of 85E813540F0AB405", res_b, PT1);
		load_key(KEY2);  // Engines idle, reload accepted
		pulse_starts(1'b1, des_pkg::op_encrypt, PT2, 1'b0, des_pkg::op_encrypt, '0);
		wait_jobs(1'b1, 1'b0, JOB_TIMEOUT, seen_a, seen_b, res_a, res_b);
		assert (seen_a) else note_timeout("a_done for the second-key encryption");
		check_block("A encryption of 8787878787878787", res_a, CT2);
	endtask

	task automatic test_key_load_while_busy();
		logic            seen_a, seen_b;
		des_pkg::block_t res_a, res_b;
		pulse_starts(1'b1, des_pkg::op_encrypt, PT2, 1'b0, des_pkg::op_encrypt, '0);
		@(posedge clk);
		key_load <= 1'b1;  // Engine A mid-job, must be dropped
		key      <= KEY1;
		@(posedge clk);
		key_load <= 1'b0;
		wait_jobs(1'b1, 1'b0, JOB_TIMEOUT, seen_a, seen_b, res_a, res_b);
		assert (seen_a) else note_timeout("a_done for the job under a key_load");
		check_block("A result with key_load during the job", res_a, CT2);
		check_flag("key_ready after ignored key_load", key_ready, 1'b1);
	endtask

	task automatic test_concurrent_channels();
		des_pkg::block_t plain_a, cipher_b;
		des_pkg::block_t res_a, res_b, back_a, back_b;
		logic            seen_a, seen_b;
		int              n;
		for (n = 0; n < 4; n++) begin
			plain_a  = {$random(seed), $random(seed)};
			cipher_b = {$random(seed), $random(seed)};
			pulse_starts(1'b1, des_pkg::op_encrypt, plain_a, 1'b1, des_pkg::op_decrypt, cipher_b);
			wait_jobs(1'b1, 1'b1, JOB_TIMEOUT, seen_a, seen_b, res_a, res_b);
			assert (seen_a && seen_b) else note_timeout("done on both channels, first pass");
			// Roles swapped, each result goes back through the other channel
			pulse_starts(1'b1, des_pkg::op_encrypt, res_b, 1'b1, des_pkg::op_decrypt, res_a);
			wait_jobs(1'b1, 1'b1, JOB_TIMEOUT, seen_a, seen_b, back_a, back_b);
			assert (seen_a && seen_b) else note_timeout("done on both channels, second pass");
			check_block("A re-encryption of B plaintext", back_a, cipher_b);
			check_block("B decryption of A ciphertext", back_b, plain_a);
		end
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		key_load = 1'b0;
		key      = '0;
		a_start  = 1'b0;
		a_op     = 1'b0;
		a_block  = '0;
		b_start  = 1'b0;
		b_op     = 1'b0;
		b_block  = '0;
		errors   = 0;
		timeouts = 0;
		seed     = 32'h90d39abf;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		test_start_without_key();
		test_key_expansion();
		test_known_encrypt();
		test_known_decrypt();
		test_key_load_while_busy();
		test_concurrent_channels();
		$display("Value errors: %0d, timeouts: %0d, assertion failures: %0d", errors, timeouts,
			i_des_subsystem.u_properties.failures);
		if (errors == 0 && timeouts == 0 && i_des_subsystem.u_properties.failures == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
hw/des_pkg.sv
hw/des_key_bus_if.sv
hw/des_key_schedule.sv
hw/des_key_arbiter.sv
hw/des_round.sv
hw/des_crypt_engine.sv
hw/des_subsystem.sv
test/des_properties.sv
test/des_tb.sv

// File: Bender.yml
package:
  name: des_subsystem

export_include_dirs:
  - include

sources:
  - hw/des_pkg.sv
  - hw/des_key_bus_if.sv
  - hw/des_key_schedule.sv
  - hw/des_key_arbiter.sv
  - hw/des_round.sv
  - hw/des_crypt_engine.sv
  - hw/des_subsystem.sv
  - target: test
    files:
      - test/des_properties.sv
      - test/des_tb.sv
